// File: verification/core_stimulus.txt
# I <byte address> <instruction word>
# S <test name> <word address> <masked store data> <byte enable>
I 000 20000513
I 004 ff900093
I 008 00c00113
I 00c 002081b3
I 010 40208233
I 014 0020f2b3
I 018 0020e333
I 01c 0020c3b3
I 020 00352023
I 024 00452223
I 028 00552423
I 02c 00652623
I 030 00752823
I 034 0f00c413
I 038 07f0f493
I 03c f0016593
I 040 06408613
I 044 00852a23
I 048 00952c23
I 04c 00b52e23
I 050 02c52023
I 054 002091b3
I 058 0020d233
I 05c 4020d2b3
I 060 00209313
I 064 0020d393
I 068 4020d413
I 06c 02352223
I 070 02452423
I 074 02552623
I 078 02652823
I 07c 02752a23
I 080 02852c23
I 084 0020a1b3
I 088 0020b233
I 08c ff80a293
I 090 fff13313
I 094 02352e23
I 098 04452023
I 09c 04552223
I 0a0 04652423
I 0a4 10000b13
I 0a8 002b0183
I 0ac 002b4203
I 0b0 002b1283
I 0b4 002b5303
I 0b8 000b2383
I 0bc 04352623
I 0c0 04452823
I 0c4 04552a23
I 0c8 04652c23
I 0cc 04752e23
I 0d0 061500a3
I 0d4 06251323
I 0d8 00210463
I 0dc 1e052e23
I 0e0 00209463
I 0e4 1e052e23
I 0e8 0020c463
I 0ec 1e052e23
I 0f0 00115463
I 0f4 1e052e23
I 0f8 00116463
I 0fc 1e052e23
I 100 0020f463
I 104 1e052e23
I 108 00208e63
I 10c 00211c63
I 110 00114a63
I 114 0020d863
I 118 0020e663
I 11c 00117463
I 120 06252423
I 124 00800f6f
I 128 1e052e23
I 12c 00df0fe7
I 130 1e052e23
I 134 07e52623
I 138 07f52823
I 13c 123452b7
I 140 00001317
I 144 06552a23
I 148 06652c23
I 14c 0000006f
S add 200 00000005 f
S sub 204 ffffffed f
S and 208 00000008 f
S or 20c fffffffd f
S xor 210 fffffff5 f
S xori 214 ffffff09 f
S andi 218 00000079 f
S ori 21c ffffff0c f
S addi 220 0000005d f
S sll 224 ffff9000 f
S srl 228 000fffff f
S sra 22c ffffffff f
S slli 230 ffffffe4 f
S srli 234 3ffffffe f
S srai 238 fffffffe f
S slt 23c 00000001 f
S sltu 240 00000000 f
S slti 244 00000000 f
S sltiu 248 00000001 f
S lb 24c ffffff8a f
S lbu 250 0000008a f
S lh 254 fffff08a f
S lhu 258 0000f08a f
S lw 25c f08a7c40 f
S sb 260 0000f900 2
S sh 264 000c0000 c
S branches 268 0000000c f
S jal_link 26c 00000128 f
S jalr_link 270 00000130 f
S lui 274 12345000 f
S auipc 278 00001140 f

// File: sources.f
hdl/rv32i_types.sv
hdl/rv32i_ctrl_pkg.sv
hdl/control_rom.sv
hdl/regfile.sv
hdl/alu.sv
hdl/cmp.sv
hdl/datapath.sv
hdl/rv32i_core.sv
verification/rv32i_core_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f sources.f \
    --top-module rv32i_core_tb -o sim_rv32i_core \
    && ./obj_dir/sim_rv32i_core | tee /dev/stderr | grep -x "TEST OK" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: verification/rv32i_core_tb.sv
`timescale 1ns/1ps

module rv32i_core_tb;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic        dmem_read;
    logic        dmem_write;
    logic [3:0]  dmem_byte_enable;
    logic [31:0] dmem_wdata;
    logic [31:0] dmem_rdata;
    logic [31:0] lane_mask;
    logic        load_expected;

    logic [31:0]     imem [256];
    logic [31:0]     data_mem [256];
    logic [31:0]     exp_addr [64];
    logic [31:0]     exp_data [64];
    logic [3:0]      exp_be [64];
    logic [8*16-1:0] exp_name [64];
    int              n_instr = 0;
    int              n_stores = 0;
    int              store_idx = 0;
    logic            loaded = 1'b0;

    rv32i_core #(
        .RESET_PC (32'h0000_0000)
    ) rv32i_core_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .imem_addr        (imem_addr),
        .imem_rdata       (imem_rdata),
        .dmem_addr        (dmem_addr),
        .dmem_read        (dmem_read),
        .dmem_write       (dmem_write),
        .dmem_byte_enable (dmem_byte_enable),
        .dmem_wdata       (dmem_wdata),
        .dmem_rdata       (dmem_rdata)
    );

    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = data_mem[dmem_addr[9:2]];
    assign lane_mask = {{8{dmem_byte_enable[3]}}, {8{dmem_byte_enable[2]}},
                        {8{dmem_byte_enable[1]}}, {8{dmem_byte_enable[0]}}};

    // only a load opcode reads data memory, and never in reset.
    assign load_expected = rst_n && (imem_rdata[6:0] == 7'b0000011);

    task automatic abort_run(input string reason);
        $display("%0s", reason);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input logic [8*16-1:0] test_name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %0s %0s: expected %08h, actual %08h",
                                test_name, field, expected, actual));
        end
    endtask

    task automatic read_stimulus();
        int              fd;
        int              code;
        logic [7:0]      kind;
        logic [8*16-1:0] name;
        logic [8*80-1:0] line;
        logic [31:0]     addr;
        logic [31:0]     value;
        logic [3:0]      be;
        fd = $fopen("verification/core_stimulus.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/core_stimulus.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kind);
            if (code == 1) begin
                if (kind == "#") begin
                    code = $fgets(line, fd); // rest of a comment line.
                end else if (kind == "I") begin
                    code = $fscanf(fd, "%h %h", addr, value);
                    imem[addr[9:2]] = value;
                    n_instr = n_instr + 1;
                end else if (kind == "S") begin
                    code = $fscanf(fd, "%s %h %h %h", name, addr, value, be);
                    exp_name[n_stores] = name;
                    exp_addr[n_stores] = addr;
                    exp_data[n_stores] = value;
                    exp_be[n_stores] = be;
                    n_stores = n_stores + 1;
                end else begin
                    abort_run("stimulus file holds a line of unknown kind");
                end
            end
        end
        $fclose(fd);
        if (n_stores == 0) begin
            abort_run("stimulus file holds no expected stores");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        int i;
        rst_n = 1'b0;
        for (i = 0; i < 256; i++) begin
            imem[i] = 32'h0000_0013; // nop.
            data_mem[i] <= 32'hf08a_7c00 | {24'd0, i[7:0]}; // low byte is the word index.
        end
        read_stimulus();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        wait (store_idx == n_stores);
        $display("TEST OK");
        $finish;
    end

    // data memory takes the store at the edge that ends its cycle.
    always @(posedge clk) begin
        if (dmem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_byte_enable[b]) begin
                    data_mem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
                end
            end
        end
    end

    always @(negedge clk) begin
        compare_value("load strobe", "dmem_read", {31'd0, load_expected},
                      {31'd0, dmem_read});
        if (rst_n && dmem_write) begin
            if (store_idx >= n_stores) begin
                abort_run("a store arrived after all expected stores were seen");
            end else begin
                compare_value(exp_name[store_idx], "address", exp_addr[store_idx], dmem_addr);
                compare_value(exp_name[store_idx], "data", exp_data[store_idx],
                              dmem_wdata & lane_mask);
                compare_value(exp_name[store_idx], "byte enable", {28'd0, exp_be[store_idx]},
                              {28'd0, dmem_byte_enable});
                store_idx = store_idx + 1;
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (20 * n_instr + 100) @(posedge clk);
        abort_run($sformatf("timeout: only %0d of %0d expected stores arrived",
                            store_idx, n_stores));
    end

endmodule

// File: hdl/rv32i_core.sv
`timescale 1ns/1ps

module rv32i_core #(
    parameter rv32i_types::rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst_n,
    output rv32i_types::rv32i_word imem_addr,
    input  rv32i_types::rv32i_word imem_rdata,
    output rv32i_types::rv32i_word dmem_addr,
    output logic                   dmem_read,
    output logic                   dmem_write,
    output logic [3:0]             dmem_byte_enable,
    output rv32i_types::rv32i_word dmem_wdata,
    input  rv32i_types::rv32i_word dmem_rdata
);
    import rv32i_types::*;
    import rv32i_ctrl_pkg::*;

    rv32i_control_word ctrl;
    rv32i_opcode       opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;

    control_rom control_rom_i (
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .ctrl   (ctrl)
    );

    datapath #(
        .RESET_PC (RESET_PC)
    ) datapath_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .ctrl             (ctrl),
        .opcode           (opcode),
        .funct3           (funct3),
        .funct7           (funct7),
        .imem_addr        (imem_addr),
        .imem_rdata       (imem_rdata),
        .dmem_addr        (dmem_addr),
        .dmem_read        (dmem_read),
        .dmem_write       (dmem_write),
        .dmem_byte_enable (dmem_byte_enable),
        .dmem_wdata       (dmem_wdata),
        .dmem_rdata       (dmem_rdata)
    );

endmodule

// File: hdl/datapath.sv
`timescale 1ns/1ps

module datapath #(
    parameter rv32i_types::rv32i_word RESET_PC = 32'h0000_0000
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  rv32i_ctrl_pkg::rv32i_control_word ctrl,
    output rv32i_types::rv32i_opcode          opcode,
    output logic [2:0]                        funct3,
    output logic [6:0]                        funct7,
    output rv32i_types::rv32i_word            imem_addr,
    input  rv32i_types::rv32i_word            imem_rdata,
    output rv32i_types::rv32i_word            dmem_addr,
    output logic                              dmem_read,
    output logic                              dmem_write,
    output logic [3:0]                        dmem_byte_enable,
    output rv32i_types::rv32i_word            dmem_wdata,
    input  rv32i_types::rv32i_word            dmem_rdata
);
    import rv32i_types::*;
    import rv32i_ctrl_pkg::*;

    rv32i_word    pc;
    rv32i_word    pc_plus4;
    rv32i_word    pc_next;
    rv32i_instr_t instr;
    rv32i_word    i_imm;
    rv32i_word    s_imm;
    rv32i_word    b_imm;
    rv32i_word    u_imm;
    rv32i_word    j_imm;
    rv32i_word    rs1_data;
    rv32i_word    rs2_data;
    rv32i_word    alu_a;
    rv32i_word    alu_b;
    rv32i_word    alu_f;
    rv32i_word    cmp_b;
    logic         br_en;
    rv32i_word    load_shifted;
    rv32i_word    rd_wdata;

    assign instr = imem_rdata;
    assign opcode = rv32i_opcode'(instr.r.opcode);
    assign funct3 = instr.r.funct3;
    assign funct7 = instr.r.funct7;

    assign i_imm = {{21{instr.i.imm[11]}}, instr.i.imm[10:0]};
    assign s_imm = {{21{instr.s.imm11_5[6]}}, instr.s.imm11_5[5:0], instr.s.imm4_0};
    assign b_imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign u_imm = {instr.u.imm31_12, 12'h000};
    assign j_imm = {{12{instr.j.imm20}}, instr.j.imm19_12, instr.j.imm11, instr.j.imm10_1, 1'b0};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign pc_plus4 = pc + 32'd4;
    assign imem_addr = pc;

    always_comb begin
        case (ctrl.pcmux_sel)
            pcmux_alu_out:  pc_next = alu_f;
            pcmux_alu_mod2: pc_next = {alu_f[31:1], 1'b0};
            default:        pc_next = pc_plus4;
        endcase
        if (ctrl.opcode == op_br && !br_en) begin
            pc_next = pc_plus4; // branch not taken.
        end
    end

    regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (ctrl.load_regfile),
        .rs1      (instr.r.rs1),
        .rs2      (instr.r.rs2),
        .rd       (instr.r.rd),
        .wdata    (rd_wdata),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign alu_a = (ctrl.alumux1_sel == alumux_pc_out) ? pc : rs1_data;

    always_comb begin
        case (ctrl.alumux2_sel)
            alumux_u_imm:   alu_b = u_imm;
            alumux_b_imm:   alu_b = b_imm;
            alumux_s_imm:   alu_b = s_imm;
            alumux_j_imm:   alu_b = j_imm;
            alumux_rs2_out: alu_b = rs2_data;
            default:        alu_b = i_imm;
        endcase
    end

    alu alu_i (
        .aluop (ctrl.aluop),
        .a     (alu_a),
        .b     (alu_b),
        .f     (alu_f)
    );

    assign cmp_b = (ctrl.cmpmux_sel == cmpmux_i_imm) ? i_imm : rs2_data;

    cmp cmp_i (
        .cmpop (ctrl.cmpop),
        .a     (rs1_data),
        .b     (cmp_b),
        .br_en (br_en)
    );

    assign dmem_addr = {alu_f[31:2], 2'b00};
    assign dmem_read = ctrl.mem_read & rst_n;
    assign dmem_write = ctrl.mem_write & rst_n;
    assign dmem_wdata = rs2_data << {alu_f[1:0], 3'b000}; // move into the addressed lane.

    always_comb begin
        dmem_byte_enable = 4'b1111;
        if (ctrl.mem_write) begin
            case (store_funct3_t'(ctrl.funct3))
                sb:      dmem_byte_enable = 4'b0001 << alu_f[1:0];
                sh:      dmem_byte_enable = 4'b0011 << alu_f[1:0];
                sw:      dmem_byte_enable = 4'b1111;
                default: dmem_byte_enable = 4'b0000;
            endcase
        end
    end

    // addressed byte or halfword ends up in the low bits.
    assign load_shifted = dmem_rdata >> {alu_f[1:0], 3'b000};

    always_comb begin
        case (ctrl.regfilemux_sel)
            regfilemux_br_en:    rd_wdata = {31'd0, br_en};
            regfilemux_u_imm:    rd_wdata = u_imm;
            regfilemux_lw:       rd_wdata = dmem_rdata;
            regfilemux_pc_plus4: rd_wdata = pc_plus4;
            regfilemux_lb:       rd_wdata = {{24{load_shifted[7]}}, load_shifted[7:0]};
            regfilemux_lbu:      rd_wdata = {24'd0, load_shifted[7:0]};
            regfilemux_lh:       rd_wdata = {{16{load_shifted[15]}}, load_shifted[15:0]};
            regfilemux_lhu:      rd_wdata = {16'd0, load_shifted[15:0]};
            default:             rd_wdata = alu_f;
        endcase
    end

endmodule

// File: hdl/cmp.sv
`timescale 1ns/1ps

module cmp (
    input  rv32i_types::branch_funct3_t cmpop,
    input  rv32i_types::rv32i_word      a,
    input  rv32i_types::rv32i_word      b,
    output logic                        br_en
);
    import rv32i_types::*;

    always_comb begin
        case (cmpop)
            beq:     br_en = (a == b);
            bne:     br_en = (a != b);
            blt:     br_en = ($signed(a) < $signed(b));
            bge:     br_en = ($signed(a) >= $signed(b));
            bltu:    br_en = (a < b);
            bgeu:    br_en = (a >= b);
            default: br_en = 1'b0;
        endcase
    end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv32i_ctrl_pkg::alu_ops aluop,
    input  rv32i_types::rv32i_word a,
    input  rv32i_types::rv32i_word b,
    output rv32i_types::rv32i_word f
);
    import rv32i_ctrl_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (aluop)
            alu_add: f = a + b;
            alu_sub: f = a - b;
            alu_sll: f = a << shamt;
            alu_srl: f = a >> shamt;
            alu_sra: f = $unsigned($signed(a) >>> shamt);
            alu_xor: f = a ^ b;
            alu_or:  f = a | b;
            alu_and: f = a & b;
            default: f = a + b;
        endcase
    end

endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load,
    input  rv32i_types::rv32i_reg  rs1,
    input  rv32i_types::rv32i_reg  rs2,
    input  rv32i_types::rv32i_reg  rd,
    input  rv32i_types::rv32i_word wdata,
    output rv32i_types::rv32i_word rs1_data,
    output rv32i_types::rv32i_word rs2_data
);
    import rv32i_types::*;

    rv32i_word regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (load && rd != 5'd0) begin // x0 stays zero.
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

// File: hdl/control_rom.sv
`timescale 1ns/1ps

module control_rom (
    input  rv32i_types::rv32i_opcode         opcode,
    input  logic [2:0]                       funct3,
    input  logic [6:0]                       funct7,
    output rv32i_ctrl_pkg::rv32i_control_word ctrl
);
    import rv32i_types::*;
    import rv32i_ctrl_pkg::*;

    branch_funct3_t branch_funct3;
    load_funct3_t   load_funct3;
    arith_funct3_t  arith_funct3;

    assign branch_funct3 = branch_funct3_t'(funct3);
    assign load_funct3 = load_funct3_t'(funct3);
    assign arith_funct3 = arith_funct3_t'(funct3);

    always_comb begin
        ctrl.opcode = opcode;
        ctrl.funct3 = funct3;
        ctrl.funct7 = funct7;
        ctrl.aluop = alu_add;
        ctrl.cmpop = beq;
        ctrl.pcmux_sel = pcmux_pc_plus4;
        ctrl.alumux1_sel = alumux_rs1_out;
        ctrl.alumux2_sel = alumux_i_imm;
        ctrl.cmpmux_sel = cmpmux_rs2_out;
        ctrl.regfilemux_sel = regfilemux_alu_out;
        ctrl.load_regfile = 1'b0;
        ctrl.mem_read = 1'b0;
        ctrl.mem_write = 1'b0;

        case (opcode)
            op_lui: begin
                ctrl.load_regfile = 1'b1;
                ctrl.regfilemux_sel = regfilemux_u_imm;
            end
            op_auipc: begin
                ctrl.alumux1_sel = alumux_pc_out;
                ctrl.alumux2_sel = alumux_u_imm;
                ctrl.load_regfile = 1'b1;
            end
            op_jal: begin
                ctrl.alumux1_sel = alumux_pc_out;
                ctrl.alumux2_sel = alumux_j_imm;
                ctrl.pcmux_sel = pcmux_alu_out;
                ctrl.load_regfile = 1'b1;
                ctrl.regfilemux_sel = regfilemux_pc_plus4; // link value.
            end
            op_jalr: begin
                ctrl.pcmux_sel = pcmux_alu_mod2;
                ctrl.load_regfile = 1'b1;
                ctrl.regfilemux_sel = regfilemux_pc_plus4;
            end
            op_br: begin
                ctrl.cmpop = branch_funct3;
                ctrl.alumux1_sel = alumux_pc_out;
                ctrl.alumux2_sel = alumux_b_imm;
                ctrl.pcmux_sel = pcmux_alu_out; // only taken when br_en is high.
            end
            op_load: begin
                ctrl.load_regfile = 1'b1;
                ctrl.mem_read = 1'b1;
                case (load_funct3)
                    lb:      ctrl.regfilemux_sel = regfilemux_lb;
                    lbu:     ctrl.regfilemux_sel = regfilemux_lbu;
                    lh:      ctrl.regfilemux_sel = regfilemux_lh;
                    lhu:     ctrl.regfilemux_sel = regfilemux_lhu;
                    default: ctrl.regfilemux_sel = regfilemux_lw;
                endcase
            end
            op_store: begin
                ctrl.alumux2_sel = alumux_s_imm;
                ctrl.mem_write = 1'b1;
            end
            op_imm: begin
                ctrl.load_regfile = 1'b1;
                case (arith_funct3)
                    sr: begin
                        ctrl.aluop = funct7[5] ? alu_sra : alu_srl;
                    end
                    slt: begin
                        ctrl.cmpmux_sel = cmpmux_i_imm;
                        ctrl.cmpop = blt;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    sltu: begin
                        ctrl.cmpmux_sel = cmpmux_i_imm;
                        ctrl.cmpop = bltu;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    default: begin
                        ctrl.aluop = alu_ops'(funct3); // addi ignores funct7.
                    end
                endcase
            end
            op_reg: begin
                ctrl.alumux2_sel = alumux_rs2_out;
                ctrl.load_regfile = 1'b1;
                case (arith_funct3)
                    add: begin
                        ctrl.aluop = funct7[5] ? alu_sub : alu_add;
                    end
                    sr: begin
                        ctrl.aluop = funct7[5] ? alu_sra : alu_srl;
                    end
                    slt: begin
                        ctrl.cmpop = blt;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    sltu: begin
                        ctrl.cmpop = bltu;
                        ctrl.regfilemux_sel = regfilemux_br_en;
                    end
                    default: begin
                        ctrl.aluop = alu_ops'(funct3);
                    end
                endcase
            end
            default: ; // unsupported opcodes retire as no-ops.
        endcase
    end

endmodule

// File: hdl/rv32i_ctrl_pkg.sv
package rv32i_ctrl_pkg;

    // values line up with arith funct3 so funct3 casts straight across.
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sll = 3'd1,
        alu_sra = 3'd2,
        alu_sub = 3'd3,
        alu_xor = 3'd4,
        alu_srl = 3'd5,
        alu_or  = 3'd6,
        alu_and = 3'd7
    } alu_ops;

    typedef enum logic [1:0] {
        pcmux_pc_plus4,
        pcmux_alu_out,
        pcmux_alu_mod2 // jalr target with bit 0 cleared.
    } pcmux_sel_t;

    typedef enum logic {
        alumux_rs1_out,
        alumux_pc_out
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux_i_imm,
        alumux_u_imm,
        alumux_b_imm,
        alumux_s_imm,
        alumux_j_imm,
        alumux_rs2_out
    } alumux2_sel_t;

    typedef enum logic {
        cmpmux_rs2_out,
        cmpmux_i_imm
    } cmpmux_sel_t;

    typedef enum logic [3:0] {
        regfilemux_alu_out,
        regfilemux_br_en,
        regfilemux_u_imm,
        regfilemux_lw,
        regfilemux_pc_plus4,
        regfilemux_lb,
        regfilemux_lbu,
        regfilemux_lh,
        regfilemux_lhu
    } regfilemux_sel_t;

    typedef struct packed {
        rv32i_types::rv32i_opcode    opcode;
        logic [2:0]                  funct3;
        logic [6:0]                  funct7;
        alu_ops                      aluop;
        rv32i_types::branch_funct3_t cmpop;
        pcmux_sel_t                  pcmux_sel;
        alumux1_sel_t                alumux1_sel;
        alumux2_sel_t                alumux2_sel;
        cmpmux_sel_t                 cmpmux_sel;
        regfilemux_sel_t             regfilemux_sel;
        logic                        load_regfile;
        logic                        mem_read;
        logic                        mem_write;
    } rv32i_control_word;

endpackage

// File: hdl/rv32i_types.sv
package rv32i_types;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0] rv32i_reg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101, // srl or sra, told apart by funct7[5].
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    typedef struct packed {
        logic [6:0] funct7;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm11_5;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        logic [4:0] imm4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } rv32i_instr_t;

endpackage
